// ==== common/dvs_hssl_pkg.sv ====
//--------------------------------------------------------------------
// shared widths, config address map and packed types
// num_channels must equal 2**chan_bits and queue_depth a power of two
//--------------------------------------------------------------------
`default_nettype none

package dvs_hssl_pkg;

  // sizes
  localparam int key_bits     = 32;
  localparam int num_channels = 8;
  localparam int chan_bits    = 3;
  localparam int num_routes   = 16;
  localparam int num_fields   = 4;
  localparam int shift_bits   = 3;
  localparam int queue_depth  = 4;

  // config address map, word addresses
  localparam int addr_map_key          = 0;
  localparam int addr_field_mask_base  = 1;
  localparam int addr_field_shift_base = 5;
  localparam int addr_route_key_base   = 16;
  localparam int addr_route_mask_base  = 32;
  localparam int addr_route_chan_base  = 48;

  typedef struct packed {
    logic                we;
    logic [7:0]          addr;
    logic [key_bits-1:0] data;
  } cfg_t;

  typedef struct packed {
    logic [key_bits-1:0]  key;
    logic [key_bits-1:0]  mask;
    logic [chan_bits-1:0] route;
  } route_entry_t;

  typedef struct packed {
    logic [key_bits-1:0]   mask;
    logic [shift_bits-1:0] shift;
  } field_t;

  // channel travels with the key on the link
  typedef struct packed {
    logic [chan_bits-1:0] chan;
    logic [key_bits-1:0]  key;
  } link_pkt_t;

endpackage

`default_nettype wire

// ==== rtl/cfg_regs.sv ====
//--------------------------------------------------------------------
// mapper and routing table registers, write only, no handshake
// writes land on the next edge, unmapped addresses are ignored
//--------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module cfg_regs
(
  input  wire logic                                               pl_clk0_buf_int,
  input  wire logic                                               rst,
  input  wire dvs_hssl_pkg::cfg_t                                 cfg,
  output logic [dvs_hssl_pkg::key_bits-1:0]                       map_key,
  output dvs_hssl_pkg::field_t [dvs_hssl_pkg::num_fields-1:0]     fields,
  output dvs_hssl_pkg::route_entry_t [dvs_hssl_pkg::num_routes-1:0] routes
);

  //------------------------------------------------------------------
  // address decode and register update
  //------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (rst)
    begin
      // all zero, so route entry 0 catches every key to channel 0
      map_key <= '0;
      fields  <= '0;
      routes  <= '0;
    end
    else if (cfg.we)
    begin
      if (cfg.addr == 8'(dvs_hssl_pkg::addr_map_key))
        map_key <= cfg.data;

      // mapper fields, masks then shifts
      for (int f = 0; f < dvs_hssl_pkg::num_fields; f++)
      begin
        if (cfg.addr == 8'(dvs_hssl_pkg::addr_field_mask_base + f))
          fields[f].mask <= cfg.data;
        if (cfg.addr == 8'(dvs_hssl_pkg::addr_field_shift_base + f))
          fields[f].shift <= cfg.data[dvs_hssl_pkg::shift_bits-1:0];
      end

      // routing table, three banks of num_routes words
      for (int r = 0; r < dvs_hssl_pkg::num_routes; r++)
      begin
        if (cfg.addr == 8'(dvs_hssl_pkg::addr_route_key_base + r))
          routes[r].key <= cfg.data;
        if (cfg.addr == 8'(dvs_hssl_pkg::addr_route_mask_base + r))
          routes[r].mask <= cfg.data;
        // only the low chan_bits of the word are kept
        if (cfg.addr == 8'(dvs_hssl_pkg::addr_route_chan_base + r))
          routes[r].route <= cfg.data[dvs_hssl_pkg::chan_bits-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/event_mapper.sv ====
//--------------------------------------------------------------------
// event to packet key, one output register, one item in flight
// config must be stable while events are being mapped
//--------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module event_mapper
(
  input  wire logic                                           pl_clk0_buf_int,
  input  wire logic                                           rst,
  input  wire logic [dvs_hssl_pkg::key_bits-1:0]              map_key,
  input  wire dvs_hssl_pkg::field_t [dvs_hssl_pkg::num_fields-1:0] fields,
  input  wire logic [dvs_hssl_pkg::key_bits-1:0]              evt_data,
  input  wire logic                                           evt_valid,
  output logic                                                evt_ready,
  output logic [dvs_hssl_pkg::key_bits-1:0]                   key_data,
  output logic                                                key_valid,
  input  wire logic                                           key_ready
);

  logic [dvs_hssl_pkg::key_bits-1:0] mapped_key;

  //------------------------------------------------------------------
  // mapping rule
  //------------------------------------------------------------------
  // base key OR each masked field, shifted right logically
  always_comb
  begin
    mapped_key = map_key;
    for (int f = 0; f < dvs_hssl_pkg::num_fields; f++)
      mapped_key = mapped_key | ((evt_data & fields[f].mask) >> fields[f].shift);
  end

  //------------------------------------------------------------------
  // output register
  //------------------------------------------------------------------
  // accept when empty or draining this cycle
  assign evt_ready = !key_valid || key_ready;

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (rst)
      key_valid <= 1'b0;
    else if (evt_ready)
      key_valid <= evt_valid;
  end

  // key payload, loaded on accept
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (evt_valid && evt_ready)
      key_data <= mapped_key;
  end

endmodule

`default_nettype wire

// ==== routing/pkt_router.sv ====
//--------------------------------------------------------------------
// first-match ternary routing, lowest index wins
// unmatched keys drop at once, counters wrap at 2**32
//--------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module pkt_router
(
  input  wire logic                                                 pl_clk0_buf_int,
  input  wire logic                                                 rst,
  input  wire dvs_hssl_pkg::route_entry_t [dvs_hssl_pkg::num_routes-1:0] routes,
  input  wire logic [dvs_hssl_pkg::key_bits-1:0]                    key_data,
  input  wire logic                                                 key_valid,
  output logic                                                      key_ready,
  output logic [dvs_hssl_pkg::key_bits-1:0]                         q_in_key,
  output logic [dvs_hssl_pkg::num_channels-1:0]                     q_in_valid,
  input  wire logic [dvs_hssl_pkg::num_channels-1:0]                q_in_ready,
  output logic [31:0]                                               routed_count,
  output logic [31:0]                                               dropped_count
);

  logic                               hit;
  logic [dvs_hssl_pkg::chan_bits-1:0] hit_chan;

  // stage register
  logic                               st_valid;
  logic [dvs_hssl_pkg::key_bits-1:0]  st_key;
  logic                               st_hit;
  logic [dvs_hssl_pkg::chan_bits-1:0] st_chan;
  logic                               st_leave;

  //------------------------------------------------------------------
  // priority search
  //------------------------------------------------------------------
  // scan from the top so the lowest match is written last
  always_comb
  begin
    hit      = 1'b0;
    hit_chan = '0;
    for (int r = dvs_hssl_pkg::num_routes - 1; r >= 0; r--)
    begin
      if ((key_data & routes[r].mask) == routes[r].key)
      begin
        hit      = 1'b1;
        hit_chan = routes[r].route;
      end
    end
  end

  //------------------------------------------------------------------
  // stage and queue steering
  //------------------------------------------------------------------
  // drops leave right away, hits wait for their queue
  assign st_leave  = !st_hit || q_in_ready[st_chan];
  assign key_ready = !st_valid || st_leave;
  assign q_in_key  = st_key;

  always_comb
  begin
    q_in_valid = '0;
    if (st_valid && st_hit)
      q_in_valid[st_chan] = 1'b1;
  end

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (rst)
      st_valid <= 1'b0;
    else if (key_ready)
      st_valid <= key_valid;
  end

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (key_valid && key_ready)
    begin
      st_key  <= key_data;
      st_hit  <= hit;
      st_chan <= hit_chan;
    end
  end

  // routed counts on queue write, dropped as the packet leaves
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (rst)
    begin
      routed_count  <= '0;
      dropped_count <= '0;
    end
    else if (st_valid)
    begin
      if (st_hit && q_in_ready[st_chan])
        routed_count <= routed_count + 32'd1;
      if (!st_hit)
        dropped_count <= dropped_count + 32'd1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/channel_queue.sv ====
//--------------------------------------------------------------------
// circular FIFO of packet keys, valid/ready on both sides
// queue_depth must be a power of two for pointer wrap
//--------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module channel_queue
(
  input  wire logic                              pl_clk0_buf_int,
  input  wire logic                              rst,
  input  wire logic [dvs_hssl_pkg::key_bits-1:0] in_key,
  input  wire logic                              in_valid,
  output logic                                   in_ready,
  output logic [dvs_hssl_pkg::key_bits-1:0]      out_key,
  output logic                                   out_valid,
  input  wire logic                              out_ready
);

  typedef logic [$clog2(dvs_hssl_pkg::queue_depth)-1:0]   ptr_t;
  typedef logic [$clog2(dvs_hssl_pkg::queue_depth+1)-1:0] count_t;

  logic [dvs_hssl_pkg::key_bits-1:0] mem [dvs_hssl_pkg::queue_depth];
  ptr_t                              wr_ptr;
  ptr_t                              rd_ptr;
  count_t                            count;
  logic                              push;
  logic                              pop;

  // full at queue_depth, head visible the cycle after a write
  assign in_ready  = count != count_t'(dvs_hssl_pkg::queue_depth);
  assign out_valid = count != '0;
  assign out_key   = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // storage
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (push)
      mem[wr_ptr] <= in_key;
  end

  // pointers and occupancy
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/channel_arbiter.sv ====
//--------------------------------------------------------------------
// round-robin merge of channel queues onto one registered link port
// rotation relies on num_channels == 2**chan_bits
//--------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module channel_arbiter
(
  input  wire logic                                                        pl_clk0_buf_int,
  input  wire logic                                                        rst,
  input  wire logic [dvs_hssl_pkg::num_channels-1:0][dvs_hssl_pkg::key_bits-1:0] q_out_key,
  input  wire logic [dvs_hssl_pkg::num_channels-1:0]                       q_out_valid,
  output logic [dvs_hssl_pkg::num_channels-1:0]                            q_out_ready,
  output dvs_hssl_pkg::link_pkt_t                                          link_pkt,
  output logic                                                             link_valid,
  input  wire logic                                                        link_ready
);

  logic [dvs_hssl_pkg::chan_bits-1:0] last;
  logic [dvs_hssl_pkg::chan_bits-1:0] pick;
  logic [dvs_hssl_pkg::chan_bits-1:0] idx;
  logic                               grant;

  //------------------------------------------------------------------
  // next nonempty channel above the last one served
  //------------------------------------------------------------------
  // largest offset first, so the nearest channel wins
  always_comb
  begin
    pick = last;
    idx  = last;
    for (int i = dvs_hssl_pkg::num_channels; i >= 1; i--)
    begin
      idx = last + i[dvs_hssl_pkg::chan_bits-1:0];
      if (q_out_valid[idx])
        pick = idx;
    end
  end

  // pop only when the output register is free or draining
  assign grant = (|q_out_valid) && (!link_valid || link_ready);

  always_comb
  begin
    q_out_ready = '0;
    if (grant)
      q_out_ready[pick] = 1'b1;
  end

  //------------------------------------------------------------------
  // output register
  //------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (rst)
    begin
      link_valid <= 1'b0;
      last       <= '0;
    end
    else if (grant)
    begin
      link_valid <= 1'b1;
      last       <= pick;
    end
    else if (link_ready)
      link_valid <= 1'b0;
  end

  // packet labelled with its channel
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (grant)
    begin
      link_pkt.chan <= pick;
      link_pkt.key  <= q_out_key[pick];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dvs_hssl_top.sv ====
//--------------------------------------------------------------------
// event to link packet transmit path, single clock domain
// min latency evt accept to link_valid is 4 cycles
//--------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module dvs_hssl_top
(
  input  wire logic                       pl_clk0_buf_int,
  input  wire logic                       rst,
  input  wire dvs_hssl_pkg::cfg_t         cfg,
  input  wire logic [31:0]                evt_data,
  input  wire logic                       evt_valid,
  output logic                            evt_ready,
  output dvs_hssl_pkg::link_pkt_t         link_pkt,
  output logic                            link_valid,
  input  wire logic                       link_ready,
  output logic [31:0]                     routed_count,
  output logic [31:0]                     dropped_count
);

  //------------------------------------------------------------------
  // internal signals
  //------------------------------------------------------------------
  logic [dvs_hssl_pkg::key_bits-1:0]                                 map_key;
  dvs_hssl_pkg::field_t [dvs_hssl_pkg::num_fields-1:0]               fields;
  dvs_hssl_pkg::route_entry_t [dvs_hssl_pkg::num_routes-1:0]         routes;

  // mapper to router
  logic [dvs_hssl_pkg::key_bits-1:0]                                 key_data;
  logic                                                              key_valid;
  logic                                                              key_ready;

  // router to queues, key shared by all channels
  logic [dvs_hssl_pkg::key_bits-1:0]                                 q_in_key;
  logic [dvs_hssl_pkg::num_channels-1:0]                             q_in_valid;
  logic [dvs_hssl_pkg::num_channels-1:0]                             q_in_ready;

  // queues to arbiter
  logic [dvs_hssl_pkg::num_channels-1:0][dvs_hssl_pkg::key_bits-1:0] q_out_key;
  logic [dvs_hssl_pkg::num_channels-1:0]                             q_out_valid;
  logic [dvs_hssl_pkg::num_channels-1:0]                             q_out_ready;

  //------------------------------------------------------------------
  // config registers and event mapper
  //------------------------------------------------------------------
  cfg_regs i_cfg_regs (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst),
    .cfg             (cfg),
    .map_key         (map_key),
    .fields          (fields),
    .routes          (routes)
  );

  event_mapper i_event_mapper (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst),
    .map_key         (map_key),
    .fields          (fields),
    .evt_data        (evt_data),
    .evt_valid       (evt_valid),
    .evt_ready       (evt_ready),
    .key_data        (key_data),
    .key_valid       (key_valid),
    .key_ready       (key_ready)
  );

  //------------------------------------------------------------------
  // routing, per-channel queues, merge onto the link
  //------------------------------------------------------------------
  pkt_router i_pkt_router (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst),
    .routes          (routes),
    .key_data        (key_data),
    .key_valid       (key_valid),
    .key_ready       (key_ready),
    .q_in_key        (q_in_key),
    .q_in_valid      (q_in_valid),
    .q_in_ready      (q_in_ready),
    .routed_count    (routed_count),
    .dropped_count   (dropped_count)
  );

  // one queue per channel
  for (genvar ch = 0; ch < dvs_hssl_pkg::num_channels; ch++)
  begin : g_queue
    channel_queue i_channel_queue (
      .pl_clk0_buf_int (pl_clk0_buf_int),
      .rst             (rst),
      .in_key          (q_in_key),
      .in_valid        (q_in_valid[ch]),
      .in_ready        (q_in_ready[ch]),
      .out_key         (q_out_key[ch]),
      .out_valid       (q_out_valid[ch]),
      .out_ready       (q_out_ready[ch])
    );
  end

  channel_arbiter i_channel_arbiter (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst),
    .q_out_key       (q_out_key),
    .q_out_valid     (q_out_valid),
    .q_out_ready     (q_out_ready),
    .link_pkt        (link_pkt),
    .link_valid      (link_valid),
    .link_ready      (link_ready)
  );

endmodule

`default_nettype wire

// ==== test/tb_dvs_hssl.sv ====
//--------------------------------------------------------------------
// testbench for the event to link path, reference model and scoreboard
// config is only rewritten while the whole path is drained
//--------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module tb_dvs_hssl;

  localparam int num_events = 128;
  localparam int max_cycles = 20 * num_events + 200;

  logic                     pl_clk0_buf_int = 1'b0;
  logic                     rst = 1'b1;
  dvs_hssl_pkg::cfg_t       cfg = '0;
  logic [31:0]              evt_data = '0;
  logic                     evt_valid = 1'b0;
  logic                     evt_ready;
  dvs_hssl_pkg::link_pkt_t  link_pkt;
  logic                     link_valid;
  logic                     link_ready = 1'b1;
  logic [31:0]              routed_count;
  logic [31:0]              dropped_count;

  // testbench copy of the config registers
  logic [31:0]                                                  tb_map_key = '0;
  logic [dvs_hssl_pkg::num_fields-1:0][31:0]                    tb_mask = '0;
  logic [dvs_hssl_pkg::num_fields-1:0][2:0]                     tb_shift = '0;
  logic [dvs_hssl_pkg::num_routes-1:0][31:0]                    tb_rkey = '0;
  logic [dvs_hssl_pkg::num_routes-1:0][31:0]                    tb_rmask = '0;
  logic [dvs_hssl_pkg::num_routes-1:0][dvs_hssl_pkg::chan_bits-1:0] tb_rchan = '0;

  // scoreboard state
  logic [31:0] exp_q [dvs_hssl_pkg::num_channels][$];
  int          errors = 0;
  int          exp_drops = 0;
  int          exp_routed = 0;
  int          link_count = 0;
  int          cycles = 0;
  logic        bp_on = 1'b0;
  string       cur_test = "reset";

  dvs_hssl_top i_dvs_hssl_top (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst             (rst),
    .cfg             (cfg),
    .evt_data        (evt_data),
    .evt_valid       (evt_valid),
    .evt_ready       (evt_ready),
    .link_pkt        (link_pkt),
    .link_valid      (link_valid),
    .link_ready      (link_ready),
    .routed_count    (routed_count),
    .dropped_count   (dropped_count)
  );

  always #4 pl_clk0_buf_int = ~pl_clk0_buf_int;

  //------------------------------------------------------------------
  // reference model and helpers
  //------------------------------------------------------------------
  // mapping then first-match lookup, returns 0 for a drop
  function automatic logic ref_route(input logic [31:0] evt, output logic [31:0] key,
                                     output logic [dvs_hssl_pkg::chan_bits-1:0] chan);
    logic found;
    found = 1'b0;
    chan  = '0;
    key   = tb_map_key;
    for (int f = 0; f < dvs_hssl_pkg::num_fields; f++)
      key = key | ((evt & tb_mask[f]) >> tb_shift[f]);
    for (int r = 0; r < dvs_hssl_pkg::num_routes; r++)
    begin
      if (!found && ((key & tb_rmask[r]) == tb_rkey[r]))
      begin
        found = 1'b1;
        chan  = tb_rchan[r];
      end
    end
    return found;
  endfunction

  function automatic int pending_packets();
    int n;
    n = 0;
    for (int ch = 0; ch < dvs_hssl_pkg::num_channels; ch++)
      n += exp_q[ch].size();
    return n;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  // one config write, mirrored into the local copy
  task automatic cfg_write(input int addr, input logic [31:0] data);
    cfg.we   = 1'b1;
    cfg.addr = 8'(addr);
    cfg.data = data;
    if (addr == dvs_hssl_pkg::addr_map_key)
      tb_map_key = data;
    for (int f = 0; f < dvs_hssl_pkg::num_fields; f++)
    begin
      if (addr == dvs_hssl_pkg::addr_field_mask_base + f)
        tb_mask[f] = data;
      if (addr == dvs_hssl_pkg::addr_field_shift_base + f)
        tb_shift[f] = data[2:0];
    end
    for (int r = 0; r < dvs_hssl_pkg::num_routes; r++)
    begin
      if (addr == dvs_hssl_pkg::addr_route_key_base + r)
        tb_rkey[r] = data;
      if (addr == dvs_hssl_pkg::addr_route_mask_base + r)
        tb_rmask[r] = data;
      if (addr == dvs_hssl_pkg::addr_route_chan_base + r)
        tb_rchan[r] = data[dvs_hssl_pkg::chan_bits-1:0];
    end
    @(negedge pl_clk0_buf_int);
    cfg.we = 1'b0;
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_event(input logic [31:0] evt);
    logic [31:0]                        key;
    logic [dvs_hssl_pkg::chan_bits-1:0] chan;
    logic                               took;
    if (ref_route(evt, key, chan))
    begin
      exp_q[chan].push_back(key);
      exp_routed++;
    end
    else
      exp_drops++;
    evt_data  = evt;
    evt_valid = 1'b1;
    took      = 1'b0;
    // evt_ready depends on registered state only
    while (!took)
    begin
      took = evt_ready;
      @(negedge pl_clk0_buf_int);
    end
    evt_valid = 1'b0;
  endtask

  // let drops clear the router after the last link packet
  task automatic wait_drain();
    while (pending_packets() != 0)
      @(negedge pl_clk0_buf_int);
    repeat (6) @(negedge pl_clk0_buf_int);
  endtask

  //------------------------------------------------------------------
  // link side: back-pressure, compare, timeout
  //------------------------------------------------------------------
  always @(negedge pl_clk0_buf_int)
  begin
    if (bp_on)
      link_ready = ($urandom % 4) != 0;
    else
      link_ready = 1'b1;
  end

  always @(posedge pl_clk0_buf_int)
  begin
    if (!rst && link_valid && link_ready)
    begin
      link_count++;
      if (exp_q[link_pkt.chan].size() == 0)
      begin
        errors++;
        $display("%s: unexpected packet %h on channel %0d", cur_test, link_pkt.key,
                 link_pkt.chan);
      end
      else
        check_value($sformatf("ch%0d key", link_pkt.chan), exp_q[link_pkt.chan].pop_front(),
                    link_pkt.key);
    end
  end

  always @(posedge pl_clk0_buf_int)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("timeout after %0d cycles in %s, %0d packets outstanding", cycles, cur_test,
               pending_packets());
      $display("Test failed");
      $finish;
    end
  end

  //------------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------------
  initial
  begin
    logic [31:0] rnd;
    void'($urandom(34066));
    repeat (5) @(posedge pl_clk0_buf_int);
    @(negedge pl_clk0_buf_int);
    rst = 1'b0;

    // reset state, all-zero table sends everything to channel 0 as key 0
    check_value("evt_ready", 32'd1, 32'(evt_ready));
    check_value("link_valid", 32'd0, 32'(link_valid));
    check_value("routed_count", 32'd0, routed_count);
    check_value("dropped_count", 32'd0, dropped_count);
    repeat (4) send_event($urandom);
    wait_drain();

    // base key plus four shifted fields, catch-all to channel 5
    cur_test = "mapping";
    cfg_write(dvs_hssl_pkg::addr_map_key, 32'hA500_0000);
    cfg_write(dvs_hssl_pkg::addr_field_mask_base + 0, 32'h0000_00FF);
    cfg_write(dvs_hssl_pkg::addr_field_mask_base + 1, 32'h0000_FF00);
    cfg_write(dvs_hssl_pkg::addr_field_mask_base + 2, 32'h00FF_0000);
    cfg_write(dvs_hssl_pkg::addr_field_mask_base + 3, 32'hF000_0000);
    cfg_write(dvs_hssl_pkg::addr_field_shift_base + 1, 32'd4);
    cfg_write(dvs_hssl_pkg::addr_field_shift_base + 2, 32'd7);
    cfg_write(dvs_hssl_pkg::addr_field_shift_base + 3, 32'd3);
    cfg_write(dvs_hssl_pkg::addr_route_chan_base + 0, 32'd5);
    repeat (20) send_event($urandom);
    wait_drain();

    // identity map, entry 0 overlaps entry 8, entries 1..8 spread over all channels
    cur_test = "priority";
    cfg_write(dvs_hssl_pkg::addr_map_key, 32'h0);
    cfg_write(dvs_hssl_pkg::addr_field_mask_base + 0, 32'hFFFF_FFFF);
    for (int f = 1; f < dvs_hssl_pkg::num_fields; f++)
      cfg_write(dvs_hssl_pkg::addr_field_mask_base + f, 32'h0);
    cfg_write(dvs_hssl_pkg::addr_route_key_base + 0, 32'h0000_000F);
    cfg_write(dvs_hssl_pkg::addr_route_mask_base + 0, 32'h0000_00FF);
    cfg_write(dvs_hssl_pkg::addr_route_chan_base + 0, 32'd3);
    for (int r = 1; r <= 8; r++)
    begin
      cfg_write(dvs_hssl_pkg::addr_route_key_base + r, 32'(r - 1));
      cfg_write(dvs_hssl_pkg::addr_route_mask_base + r, 32'h7);
      cfg_write(dvs_hssl_pkg::addr_route_chan_base + r, 32'(8 - r));
    end
    for (int i = 0; i < 24; i++)
    begin
      rnd = $urandom;
      if (i < 8)
        rnd[2:0] = 3'(i);
      else if (i % 4 == 0)
        rnd[7:0] = 8'h0F;
      send_event(rnd);
    end
    wait_drain();

    // low nibble 8..15 misses entries 1..8, entries 9..15 match single keys
    cur_test = "drops";
    for (int r = 1; r <= 8; r++)
      cfg_write(dvs_hssl_pkg::addr_route_mask_base + r, 32'hF);
    for (int r = 9; r < dvs_hssl_pkg::num_routes; r++)
    begin
      cfg_write(dvs_hssl_pkg::addr_route_key_base + r, {16'hDEAD, 16'(r)});
      cfg_write(dvs_hssl_pkg::addr_route_mask_base + r, 32'hFFFF_FFFF);
    end
    for (int i = 0; i < 20; i++)
    begin
      rnd = $urandom;
      // every fifth event hits one of the exact-match entries
      if (i % 5 == 0)
        rnd = {16'hDEAD, 16'(9 + i / 5)};
      send_event(rnd);
    end
    wait_drain();
    check_value("dropped_count", 32'(exp_drops), dropped_count);

    // random link stalls, same table
    cur_test = "backpressure";
    bp_on = 1'b1;
    repeat (60) send_event($urandom);
    wait_drain();
    bp_on = 1'b0;
    check_value("routed_count", 32'(exp_routed), routed_count);
    check_value("routed vs link", 32'(link_count), routed_count);
    check_value("dropped_count", 32'(exp_drops), dropped_count);

    for (int ch = 0; ch < dvs_hssl_pkg::num_channels; ch++)
    begin
      if (exp_q[ch].size() != 0)
      begin
        errors++;
        $display("channel %0d never delivered %0d expected packets", ch, exp_q[ch].size());
      end
    end
    $display("%0d errors, %0d link packets, %0d drops", errors, link_count, exp_drops);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
common/dvs_hssl_pkg.sv
rtl/cfg_regs.sv
rtl/event_mapper.sv
routing/pkt_router.sv
rtl/channel_queue.sv
rtl/channel_arbiter.sv
rtl/dvs_hssl_top.sv
test/tb_dvs_hssl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f all.f --top-module tb_dvs_hssl -o sim_tb_dvs_hssl; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_dvs_hssl)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" <<< "$output"; then
  exit 0
fi
exit 1
